// ==== Bender.yml ====
package:
  name: decode_stage

export_include_dirs:
  - src

sources:
  - src/decode_pkg.sv
  - src/decodeCtrlIf.sv
  - src/decodeControl.sv
  - src/regFile.sv
  - src/branchUnit.sv
  - src/decodeStage.sv
  - target: test
    files:
      - dv/decodeStage_chk.sv
      - dv/decodeStage_tb.sv

// ==== dv/decodeStage_chk.sv ====
`default_nettype none

`include "decode_config.svh"

module decodeStage_chk (
    input logic                 clk,
    input logic                 rst,
    input decode_pkg::word_t    instIn,
    input logic                 regWrite,
    input logic                 dMemWrite,
    input logic                 dMemEn,
    input logic                 memToReg,
    input logic                 dMemDump,
    input decode_pkg::regAddr_t rdAddr,
    input decode_pkg::word_t    pcBranch,
    input logic                 branch,
    input logic                 err
);

    import decode_pkg::*;

    opcode_t op;
    logic listed;
    logic writer;
    logic linkOp;
    int unsigned failCount = 0;

    assign op = instIn[15:11];
    assign listed = op inside {OP_HALT, OP_NOP, OP_SIIC, OP_RTI, OP_J, OP_JR, OP_JAL, OP_JALR,
        OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ,
        OP_ST, OP_LD, OP_ALU};
    assign linkOp = (op == OP_JAL) || (op == OP_JALR);
    assign writer = linkOp || (op inside {OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_LD, OP_ALU});

    errRule: assert property (@(posedge clk) disable iff (rst) err == !listed) else begin
        $error("err does not match the opcode class");
        failCount++;
    end

    // Unknown opcodes leave everything else quiet
    errQuiet: assert property (@(posedge clk) disable iff (rst)
        err |-> !(regWrite || dMemWrite || dMemEn || memToReg || dMemDump || branch)) else begin
        $error("A control output is active together with err");
        failCount++;
    end

    memRule: assert property (@(posedge clk) disable iff (rst)
        {dMemEn, dMemWrite, memToReg, dMemDump} ==
        {op == OP_ST || op == OP_LD, op == OP_ST, op == OP_LD, op == OP_HALT}) else begin
        $error("Memory or dump controls do not follow the opcode");
        failCount++;
    end

    writeRule: assert property (@(posedge clk) disable iff (rst) regWrite == writer) else begin
        $error("regWrite does not follow the opcode");
        failCount++;
    end

    destRule: assert property (@(posedge clk) disable iff (rst)
        regWrite |-> rdAddr == (op == OP_ALU ? instIn[4:2] :
                                linkOp ? `DEC_LINK_REG : instIn[7:5])) else begin
        $error("rdAddr names the wrong destination register");
        failCount++;
    end

    trapRule: assert property (@(posedge clk) disable iff (rst)
        op == OP_SIIC |-> branch && pcBranch == `DEC_TRAP_VECTOR) else begin
        $error("SIIC does not redirect to the trap vector");
        failCount++;
    end

endmodule

bind decodeStage decodeStage_chk u_chk (.*);

`default_nettype wire

// ==== dv/decodeStage_tb.sv ====
`default_nettype none

`include "decode_config.svh"

module decodeStage_tb;

    import decode_pkg::*;

    localparam int RESET_CYCLES = 16;
    // Test lengths including each settling edge
    localparam int TEST_CYCLES = (8 + 64 + 1) + (32 + 1) + (16 + 1) + (32 + 1) + (24 + 1)
                                 + (5 + 1 + RESET_CYCLES + 1 + 1);
    localparam int MAX_CYCLES = RESET_CYCLES + TEST_CYCLES + 40;
    localparam opcode_t DEST_OPS [8] = '{OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
                                         OP_LD, OP_ALU, OP_JAL, OP_JALR};
    localparam opcode_t BRANCH_OPS [4] = '{OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ};

    logic clk = 1'b0;
    logic rst;
    word_t instIn, pcPlus2In, wbData, fwdRs;
    logic wbRegWrite, fwdSel;
    regAddr_t wbRdAddr, rdAddr;
    word_t instOut, pcPlus2Out, rs, rt, pcBranch;
    logic regWrite, dMemWrite, dMemEn, memToReg, dMemDump, branch, err;

    word_t shadow [`DEC_NREGS];
    word_t shadowEpc;
    int seed = 38134;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int cycles = 0;
    int errStart = 0;

    decodeStage u_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic word_t randWord();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic int totalErrors();
        return errors + int'(u_dut.u_chk.failCount);
    endfunction

    task automatic compareValue(input string name, input word_t got, input word_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
        end
    endtask

    // One decode cycle with datapath outputs checked at the falling edge
    task automatic step(input word_t inst, input word_t pc, input logic fs, input word_t fr,
                        input logic we, input regAddr_t wa, input word_t wd);
        word_t rsVal;
        word_t imm8;
        word_t expTarget;
        logic expBranch;
        logic hasTarget;
        @(posedge clk);
        instIn <= inst;
        pcPlus2In <= pc;
        fwdSel <= fs;
        fwdRs <= fr;
        wbRegWrite <= we;
        wbRdAddr <= wa;
        wbData <= wd;
        // Bypass shows the new value in this cycle already
        if (we) begin
            shadow[wa] = wd;
        end
        @(negedge clk);
        rsVal = fs ? fr : shadow[inst[10:8]];
        imm8 = {{8{inst[7]}}, inst[7:0]};
        expTarget = pc + imm8;
        expBranch = 1'b1;
        hasTarget = 1'b1;
        case (inst[15:11])
            OP_SIIC: expTarget = `DEC_TRAP_VECTOR;
            OP_RTI: expTarget = shadowEpc;
            OP_J, OP_JAL: expTarget = pc + {{5{inst[10]}}, inst[10:0]};
            OP_JR, OP_JALR: expTarget = rsVal + imm8;
            OP_BEQZ: expBranch = (rsVal == '0);
            OP_BNEZ: expBranch = (rsVal != '0);
            OP_BLTZ: expBranch = rsVal[15];
            OP_BGEZ: expBranch = !rsVal[15];
            default: begin
                expBranch = 1'b0;
                hasTarget = 1'b0;
            end
        endcase
        compareValue("instOut", instOut, inst);
        compareValue("pcPlus2Out", pcPlus2Out, pc);
        compareValue("rs", rs, shadow[inst[10:8]]);
        compareValue("rt", rt, shadow[inst[7:5]]);
        compareValue("branch", word_t'(branch), word_t'(expBranch));
        if (hasTarget) begin
            compareValue("pcBranch", pcBranch, expTarget);
        end
        // EPC loads at the coming edge
        if (inst[15:11] == OP_SIIC) begin
            shadowEpc = pc;
        end
    endtask

    task automatic decodeAt(input word_t inst, input word_t pc);
        step(inst, pc, 1'b0, '0, 1'b0, '0, '0);
    endtask

    task automatic endTest(input string name);
        // Lets the bound assertions sample the last instruction
        @(posedge clk);
        @(negedge clk);
        $display("%s: %0d errors", name, totalErrors() - errStart);
        tests++;
        errStart = totalErrors();
    endtask

    initial begin
        word_t r;
        word_t v;
        rst = 1'b1;
        instIn = {OP_NOP, 11'd0};
        pcPlus2In = '0;
        wbData = '0;
        wbRegWrite = 1'b0;
        wbRdAddr = '0;
        fwdSel = 1'b0;
        fwdRs = '0;
        shadow = '{default: '0};
        shadowEpc = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // Rs reads the register being written
        for (int a = 0; a < `DEC_NREGS; a++) begin
            step({OP_NOP, 3'(a), 3'(a + 1), 5'd0}, randWord(), 1'b0, '0,
                 1'b1, 3'(a), randWord());
        end
        for (int a = 0; a < 64; a++) begin
            decodeAt({OP_NOP, 6'(a), 5'd0}, randWord());
        end
        endTest("register write and read");

        for (int op = 0; op < 32; op++) begin
            r = randWord();
            decodeAt({5'(op), r[10:0]}, randWord());
        end
        endTest("control decode");

        for (int i = 0; i < 16; i++) begin
            r = randWord();
            decodeAt({DEST_OPS[i % 8], r[10:0]}, randWord());
        end
        endTest("destination register");

        // Zero, negative and positive Rs against every branch
        for (int i = 0; i < 16; i++) begin
            r = randWord();
            case (i % 3)
                0: v = '0;
                1: v = r | 16'h8000;
                default: v = (r & 16'h7fff) | 16'h0001;
            endcase
            step({OP_NOP, 11'd0}, randWord(), 1'b0, '0, 1'b1, 3'(i), v);
            r = randWord();
            decodeAt({BRANCH_OPS[i % 4], 3'(i), r[7:0]}, randWord());
        end
        endTest("branch resolution");

        for (int i = 0; i < 4; i++) begin
            r = randWord();
            decodeAt({OP_J, r[10:0]}, randWord());
            decodeAt({OP_JAL, r[10:0]}, randWord());
            decodeAt({OP_JR, 3'(i), r[7:0]}, randWord());
            decodeAt({OP_JALR, 3'(i + 4), r[7:0]}, randWord());
            step({OP_JR, 3'(i), r[7:0]}, randWord(), 1'b1, randWord(), 1'b0, '0, '0);
            step({OP_JALR, 3'(i + 4), r[7:0]}, randWord(), 1'b1, randWord(), 1'b0, '0, '0);
        end
        endTest("jumps with forwarding");

        decodeAt({OP_SIIC, 11'd0}, randWord());
        decodeAt({OP_NOP, 11'd0}, randWord());
        decodeAt({OP_RTI, 11'd0}, randWord());
        decodeAt({OP_SIIC, 11'h5a5}, randWord());
        decodeAt({OP_RTI, 11'd0}, randWord());
        @(posedge clk);
        rst <= 1'b1;
        instIn <= {OP_NOP, 11'd0};
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        shadow = '{default: '0};
        shadowEpc = '0;
        decodeAt({OP_RTI, 11'd0}, randWord());
        endTest("trap and return");

        $display("Tests: %0d, checks: %0d, mismatches: %0d, assertion failures: %0d",
                 tests, checks, errors, u_dut.u_chk.failCount);
        if (totalErrors() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/branchUnit.sv ====
`default_nettype none

`include "decode_config.svh"

module branchUnit (
    input  logic              clk,
    input  logic              rst,
    input  decode_pkg::word_t instIn,
    input  decode_pkg::word_t pcPlus2,
    input  decode_pkg::word_t rs,
    input  decode_pkg::word_t fwdRs,
    input  logic              fwdSel,
    decodeCtrlIf.branch       ctl,
    output decode_pkg::word_t pcBranch,
    output logic              branch
);

    import decode_pkg::*;

    word_t rsEff;
    word_t epc;
    word_t base;
    word_t offset;
    word_t imm8Ext;
    word_t imm11Ext;
    logic rsZero;
    logic rsNeg;
    logic condTaken;

    assign rsEff = fwdSel ? fwdRs : rs;

    assign rsZero = (rsEff == '0);
    assign rsNeg = rsEff[`DEC_WORD_W-1];

    // EQZ, NEZ, LTZ, GEZ
    always_comb begin
        case (instIn[12:11])
            2'b00: condTaken = rsZero;
            2'b01: condTaken = !rsZero;
            2'b10: condTaken = rsNeg;
            default: condTaken = !rsNeg;
        endcase
    end

    assign imm8Ext = {{(`DEC_WORD_W-`DEC_IMM8_W){instIn[`DEC_IMM8_W-1]}},
                      instIn[`DEC_IMM8_W-1:0]};
    assign imm11Ext = {{(`DEC_WORD_W-`DEC_IMM11_W){instIn[`DEC_IMM11_W-1]}},
                       instIn[`DEC_IMM11_W-1:0]};

    // J and JAL carry the long displacement
    assign offset = (ctl.isJump && !ctl.jumpReg) ? imm11Ext : imm8Ext;
    assign base = ctl.jumpReg ? rsEff : pcPlus2;

    always_comb begin
        if (ctl.trap) begin
            pcBranch = `DEC_TRAP_VECTOR;
        end else if (ctl.rti) begin
            pcBranch = epc;
        end else begin
            pcBranch = base + offset;
        end
    end

    assign branch = ctl.isJump | ctl.trap | ctl.rti | (ctl.isBranch & condTaken);

    // Return address for RTI
    always_ff @(posedge clk) begin
        if (rst) begin
            epc <= '0;
        end else if (ctl.trap) begin
            epc <= pcPlus2;
        end
    end

endmodule

`default_nettype wire

// ==== src/decodeControl.sv ====
`default_nettype none

`include "decode_config.svh"

module decodeControl (
    input  decode_pkg::word_t    instIn,
    output logic                 regWrite,
    output logic                 dMemWrite,
    output logic                 dMemEn,
    output logic                 memToReg,
    output logic                 dMemDump,
    output logic                 err,
    output decode_pkg::regAddr_t rdAddr,
    decodeCtrlIf.ctrl            ctl
);

    import decode_pkg::*;

    opcode_t opcode;

    assign opcode = instIn[15:11];

    always_comb begin
        regWrite = 1'b0;
        dMemWrite = 1'b0;
        dMemEn = 1'b0;
        memToReg = 1'b0;
        dMemDump = 1'b0;
        err = 1'b0;
        ctl.isBranch = 1'b0;
        ctl.isJump = 1'b0;
        ctl.jumpReg = 1'b0;
        ctl.trap = 1'b0;
        ctl.rti = 1'b0;
        // I-format destination unless overridden
        rdAddr = instIn[7:5];

        case (opcode)
            OP_HALT: begin
                dMemDump = 1'b1;
            end
            OP_NOP: begin
            end
            OP_SIIC: begin
                ctl.trap = 1'b1;
            end
            OP_RTI: begin
                ctl.rti = 1'b1;
            end
            OP_J: begin
                ctl.isJump = 1'b1;
            end
            OP_JR: begin
                ctl.isJump = 1'b1;
                ctl.jumpReg = 1'b1;
            end
            OP_JAL: begin
                ctl.isJump = 1'b1;
                regWrite = 1'b1;
                rdAddr = `DEC_LINK_REG;
            end
            OP_JALR: begin
                ctl.isJump = 1'b1;
                ctl.jumpReg = 1'b1;
                regWrite = 1'b1;
                rdAddr = `DEC_LINK_REG;
            end
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
                regWrite = 1'b1;
            end
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
                ctl.isBranch = 1'b1;
            end
            OP_ST: begin
                dMemEn = 1'b1;
                dMemWrite = 1'b1;
            end
            OP_LD: begin
                dMemEn = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            OP_ALU: begin
                regWrite = 1'b1;
                // R-format writes Rd in bits 4:2
                rdAddr = instIn[4:2];
            end
            default: begin
                err = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/decodeCtrlIf.sv ====
`default_nettype none

interface decodeCtrlIf;

    logic isBranch;
    logic isJump;
    // Target base is Rs instead of PC+2
    logic jumpReg;
    logic trap;
    logic rti;

    modport ctrl (
        output isBranch,
        output isJump,
        output jumpReg,
        output trap,
        output rti
    );

    modport branch (
        input isBranch,
        input isJump,
        input jumpReg,
        input trap,
        input rti
    );

endinterface

`default_nettype wire

// ==== src/decodeStage.sv ====
`default_nettype none

module decodeStage (
    input  logic                 clk,
    input  logic                 rst,
    input  decode_pkg::word_t    instIn,
    input  decode_pkg::word_t    pcPlus2In,
    input  decode_pkg::word_t    wbData,
    input  logic                 wbRegWrite,
    input  decode_pkg::regAddr_t wbRdAddr,
    input  logic                 fwdSel,
    input  decode_pkg::word_t    fwdRs,
    output decode_pkg::word_t    instOut,
    output decode_pkg::word_t    pcPlus2Out,
    output decode_pkg::word_t    rs,
    output decode_pkg::word_t    rt,
    output logic                 regWrite,
    output logic                 dMemWrite,
    output logic                 dMemEn,
    output logic                 memToReg,
    output logic                 dMemDump,
    output decode_pkg::regAddr_t rdAddr,
    output decode_pkg::word_t    pcBranch,
    output logic                 branch,
    output logic                 err
);

    decodeCtrlIf ctrlBus();

    // Forwarded to execute unchanged
    assign instOut = instIn;
    assign pcPlus2Out = pcPlus2In;

    decodeControl u_control (
        .instIn    (instIn),
        .regWrite  (regWrite),
        .dMemWrite (dMemWrite),
        .dMemEn    (dMemEn),
        .memToReg  (memToReg),
        .dMemDump  (dMemDump),
        .err       (err),
        .rdAddr    (rdAddr),
        .ctl       (ctrlBus.ctrl)
    );

    regFile u_regFile (
        .clk     (clk),
        .rst     (rst),
        .rdSel1  (instIn[10:8]),
        .rdSel2  (instIn[7:5]),
        .wrSel   (wbRdAddr),
        .wrData  (wbData),
        .wrEn    (wbRegWrite),
        .rdData1 (rs),
        .rdData2 (rt)
    );

    branchUnit u_branch (
        .clk      (clk),
        .rst      (rst),
        .instIn   (instIn),
        .pcPlus2  (pcPlus2In),
        .rs       (rs),
        .fwdRs    (fwdRs),
        .fwdSel   (fwdSel),
        .ctl      (ctrlBus.branch),
        .pcBranch (pcBranch),
        .branch   (branch)
    );

endmodule

`default_nettype wire

// ==== src/decode_config.svh ====
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Datapath and instruction width
`define DEC_WORD_W 16

// Register file geometry
`define DEC_NREGS 8
`define DEC_REG_AW 3
`define DEC_LINK_REG 3'd7

// Instruction fields
`define DEC_OPCODE_W 5
`define DEC_IMM8_W 8
`define DEC_IMM11_W 11

// SIIC handler entry
`define DEC_TRAP_VECTOR 16'h0002

`endif

// ==== src/decode_pkg.sv ====
`default_nettype none

`include "decode_config.svh"

package decode_pkg;

    typedef logic [`DEC_WORD_W-1:0] word_t;
    typedef logic [`DEC_REG_AW-1:0] regAddr_t;
    typedef logic [`DEC_OPCODE_W-1:0] opcode_t;

    // Special and control transfer
    localparam opcode_t OP_HALT = 5'b00000;
    localparam opcode_t OP_NOP = 5'b00001;
    localparam opcode_t OP_SIIC = 5'b00010;
    localparam opcode_t OP_RTI = 5'b00011;
    localparam opcode_t OP_J = 5'b00100;
    localparam opcode_t OP_JR = 5'b00101;
    localparam opcode_t OP_JAL = 5'b00110;
    localparam opcode_t OP_JALR = 5'b00111;

    // Immediate ALU
    localparam opcode_t OP_ADDI = 5'b01000;
    localparam opcode_t OP_SUBI = 5'b01001;
    localparam opcode_t OP_XORI = 5'b01010;
    localparam opcode_t OP_ANDNI = 5'b01011;

    // Conditional branches, bits 12:11 pick the condition
    localparam opcode_t OP_BEQZ = 5'b01100;
    localparam opcode_t OP_BNEZ = 5'b01101;
    localparam opcode_t OP_BLTZ = 5'b01110;
    localparam opcode_t OP_BGEZ = 5'b01111;

    // Memory
    localparam opcode_t OP_ST = 5'b10000;
    localparam opcode_t OP_LD = 5'b10001;

    // Register-register ALU
    localparam opcode_t OP_ALU = 5'b11011;

endpackage

`default_nettype wire

// ==== src/regFile.sv ====
`default_nettype none

`include "decode_config.svh"

module regFile (
    input  logic                 clk,
    input  logic                 rst,
    input  decode_pkg::regAddr_t rdSel1,
    input  decode_pkg::regAddr_t rdSel2,
    input  decode_pkg::regAddr_t wrSel,
    input  decode_pkg::word_t    wrData,
    input  logic                 wrEn,
    output decode_pkg::word_t    rdData1,
    output decode_pkg::word_t    rdData2
);

    import decode_pkg::*;

    word_t regs [`DEC_NREGS];
    logic hit1;
    logic hit2;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DEC_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrSel] <= wrData;
        end
    end

    // Same-cycle writeback is visible to decode
    assign hit1 = wrEn && (wrSel == rdSel1);
    assign hit2 = wrEn && (wrSel == rdSel2);

    assign rdData1 = hit1 ? wrData : regs[rdSel1];
    assign rdData2 = hit2 ? wrData : regs[rdSel2];

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/decode_pkg.sv
src/decodeCtrlIf.sv
src/decodeControl.sv
src/regFile.sv
src/branchUnit.sv
src/decodeStage.sv
dv/decodeStage_chk.sv
dv/decodeStage_tb.sv
